// File: logic/rv_backend_pkg.sv
// RV32 back end shared types
package rv_backend_pkg;

	// Datapath widths
	localparam int WORD_WIDTH    = 32;
	localparam int PC_ADDR_BITS  = 32;
	localparam int REG_ADDR_BITS = 5;

	// Write-back source select
	// WB_ALU must stay zero, a cleared MEM/WB bundle selects it
	typedef enum logic [2:0] {
		WB_ALU  = 3'd0,
		WB_DIV  = 3'd1,
		WB_LOAD = 3'd2,
		WB_IMM  = 3'd3,
		WB_PC4  = 3'd4
	} wb_sel_t;

	// Memory operation of the instruction in the MEM stage
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		LOAD_B   = 4'd1,
		LOAD_BU  = 4'd2,
		LOAD_H   = 4'd3,
		LOAD_HU  = 4'd4,
		LOAD_W   = 4'd5,
		STORE_B  = 4'd6,
		STORE_H  = 4'd7,
		STORE_W  = 4'd8
	} mem_op_t;

	// Execute result entering the back end
	// alu_out is also the byte address for loads and stores
	typedef struct packed {
		logic [PC_ADDR_BITS-1:0]  pc4;
		logic [WORD_WIDTH-1:0]    alu_out;
		logic [WORD_WIDTH-1:0]    div_out;
		logic [WORD_WIDTH-1:0]    imm;
		logic [WORD_WIDTH-1:0]    store_data;
		logic [REG_ADDR_BITS-1:0] rd;
		logic                     wr_en;
		wb_sel_t                  sel_data;
		mem_op_t                  mem_op;
	} ex_mem_t;

	// Bundle held in the MEM/WB register
	typedef struct packed {
		logic [PC_ADDR_BITS-1:0]  pc4;
		logic [WORD_WIDTH-1:0]    alu_out;
		logic [WORD_WIDTH-1:0]    div_out;
		logic [WORD_WIDTH-1:0]    load_data;
		logic [WORD_WIDTH-1:0]    imm;
		logic [REG_ADDR_BITS-1:0] rd;
		logic                     wr_en;
		wb_sel_t                  sel_data;
	} mem_wb_t;

	// One memory word, seen as byte lanes or halfword lanes
	typedef union packed {
		logic [3:0][7:0]  byte_lane;
		logic [1:0][15:0] half_lane;
	} mem_word_u;

endpackage

// File: logic/data_mem.sv
// Word-addressed data memory
module data_mem import rv_backend_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [WORD_WIDTH-1:0] mem_addr,
	input  logic [WORD_WIDTH-1:0] mem_wdata,
	input  logic [3:0]            mem_be,
	input  logic                  mem_we,
	output mem_word_u             mem_rdata
);

	// Storage, no reset on contents
	mem_word_u mem [DMEM_WORDS];

	// Word index from address bits above the byte offset
	logic [WORD_WIDTH-1:0] word_idx;

	// Wraps around the depth
	assign word_idx = {2'b00, mem_addr[WORD_WIDTH-1:2]} % DMEM_WORDS;

	// Byte-lane write at the edge
	// Held off while in reset
	always_ff @(posedge clk) begin
		if (rst_n && mem_we) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_be[i]) begin
					mem[word_idx].byte_lane[i] <= mem_wdata[8*i +: 8];
				end
			end
		end
	end

	// Asynchronous read
	// A load right after a store to the same word sees the new data
	assign mem_rdata = mem[word_idx];

endmodule

// File: logic/mem_stage.sv
// Memory access stage
module mem_stage import rv_backend_pkg::*; (
	input  ex_mem_t               ex_in,
	output logic [WORD_WIDTH-1:0] mem_addr,
	output logic [WORD_WIDTH-1:0] mem_wdata,
	output logic [3:0]            mem_be,
	output logic                  mem_we,
	input  mem_word_u             mem_rdata,
	output mem_wb_t               mem_out
);

	// Offset of the access within the word
	logic [1:0] byte_off;

	// Selected lanes from the read word
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;

	// Aligned and extended load result
	logic [WORD_WIDTH-1:0] load_val;

	// ALU result is the byte address
	assign mem_addr = ex_in.alu_out;
	assign byte_off = ex_in.alu_out[1:0];

	// Store decode
	// Data is replicated so every enabled lane has the right bytes
	always_comb begin
		mem_we    = 1'b0;
		mem_be    = 4'b0000;
		mem_wdata = '0;
		case (ex_in.mem_op)
			STORE_B: begin
				mem_we    = 1'b1;
				mem_be    = 4'b0001 << byte_off;
				mem_wdata = {4{ex_in.store_data[7:0]}};
			end
			STORE_H: begin
				mem_we = 1'b1;
				// Low offset bit ignored, halfword aligned
				mem_be    = byte_off[1] ? 4'b1100 : 4'b0011;
				mem_wdata = {2{ex_in.store_data[15:0]}};
			end
			STORE_W: begin
				mem_we    = 1'b1;
				mem_be    = 4'b1111;
				mem_wdata = ex_in.store_data;
			end
			default: begin
				mem_we = 1'b0;
			end
		endcase
	end

	// Byte and halfword views of the same word
	assign ld_byte = mem_rdata.byte_lane[byte_off];
	assign ld_half = mem_rdata.half_lane[byte_off[1]];

	// Load alignment and extension
	always_comb begin
		case (ex_in.mem_op)
			LOAD_B:  load_val = {{(WORD_WIDTH-8){ld_byte[7]}}, ld_byte};
			LOAD_BU: load_val = {{(WORD_WIDTH-8){1'b0}}, ld_byte};
			LOAD_H:  load_val = {{(WORD_WIDTH-16){ld_half[15]}}, ld_half};
			LOAD_HU: load_val = {{(WORD_WIDTH-16){1'b0}}, ld_half};
			LOAD_W:  load_val = mem_rdata;
			// Non-loads carry zero
			default: load_val = '0;
		endcase
	end

	// Bundle for the MEM/WB register
	always_comb begin
		mem_out.pc4       = ex_in.pc4;
		mem_out.alu_out   = ex_in.alu_out;
		mem_out.div_out   = ex_in.div_out;
		mem_out.load_data = load_val;
		mem_out.imm       = ex_in.imm;
		mem_out.rd        = ex_in.rd;
		// Control passes straight through
		mem_out.wr_en    = ex_in.wr_en;
		mem_out.sel_data = ex_in.sel_data;
	end

endmodule

// File: logic/pipereg_mem_wb.sv
// MEM/WB pipeline register
module pipereg_mem_wb import rv_backend_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    flush,
	input  mem_wb_t mem_out,
	output mem_wb_t wb_in
);

	// Inert bundle, no register write and ALU source
	localparam mem_wb_t WB_CLEAR = '{
		pc4:       '0,
		alu_out:   '0,
		div_out:   '0,
		load_data: '0,
		imm:       '0,
		rd:        '0,
		wr_en:     1'b0,
		sel_data:  WB_ALU
	};

	// One stage of delay
	// Flush drops the instruction in place of capturing it
	always_ff @(posedge clk) begin
		if (!rst_n || flush) begin
			wb_in <= WB_CLEAR;
		end else begin
			wb_in <= mem_out;
		end
	end

endmodule

// File: logic/wb_regfile.sv
// Write-back and register file
module wb_regfile import rv_backend_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  mem_wb_t                  wb_in,
	input  logic [REG_ADDR_BITS-1:0] rd_addr,
	output logic [WORD_WIDTH-1:0]    rd_data
);

	localparam int NUM_REGS = 2**REG_ADDR_BITS;

	// Integer registers, x0 included but never written after reset
	logic [WORD_WIDTH-1:0] regs [NUM_REGS];

	// Value selected for write-back
	logic [WORD_WIDTH-1:0] wr_val;

	// Write-back source mux
	always_comb begin
		case (wb_in.sel_data)
			WB_ALU:  wr_val = wb_in.alu_out;
			WB_DIV:  wr_val = wb_in.div_out;
			WB_LOAD: wr_val = wb_in.load_data;
			WB_IMM:  wr_val = wb_in.imm;
			WB_PC4:  wr_val = wb_in.pc4;
			// Unused codes
			default: wr_val = '0;
		endcase
	end

	// Register write at the edge
	// Reset clears the whole file
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_in.wr_en && (wb_in.rd != '0)) begin
			regs[wb_in.rd] <= wr_val;
		end
	end

	// Combinational read, no bypass
	// x0 forced to zero
	assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

// File: logic/rv_backend_top.sv
// RV32 back end top level
module rv_backend_top import rv_backend_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     flush,
	input  ex_mem_t                  ex_in,
	input  logic [REG_ADDR_BITS-1:0] rd_addr,
	output logic [WORD_WIDTH-1:0]    rd_data
);

	// Memory stage to data memory
	logic [WORD_WIDTH-1:0] mem_addr;
	logic [WORD_WIDTH-1:0] mem_wdata;
	logic [3:0]            mem_be;
	logic                  mem_we;
	mem_word_u             mem_rdata;

	// Stage bundles
	mem_wb_t mem_out;
	mem_wb_t wb_in;

	// Loads, stores and bundle assembly
	mem_stage u_mem_stage (
		.ex_in     (ex_in),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_be    (mem_be),
		.mem_we    (mem_we),
		.mem_rdata (mem_rdata),
		.mem_out   (mem_out)
	);

	data_mem #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_data_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_be    (mem_be),
		.mem_we    (mem_we),
		.mem_rdata (mem_rdata)
	);

	pipereg_mem_wb u_pipereg_mem_wb (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.mem_out (mem_out),
		.wb_in   (wb_in)
	);

	// Register write one edge after capture
	wb_regfile u_wb_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.wb_in   (wb_in),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// File: tests/rv_backend_tb.sv
// RV32 back end testbench
module rv_backend_tb import rv_backend_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_VECS     = 128;
	localparam string VEC_FILE  = "tests/rv_backend_vectors.txt";

	// Columns of one vector line
	localparam int FIELDS  = 14;
	localparam int F_TEST  = 0;
	localparam int F_FLUSH = 1;
	localparam int F_PC4   = 2;
	localparam int F_ALU   = 3;
	localparam int F_DIV   = 4;
	localparam int F_IMM   = 5;
	localparam int F_SDATA = 6;
	localparam int F_RD    = 7;
	localparam int F_WE    = 8;
	localparam int F_SEL   = 9;
	localparam int F_MOP   = 10;
	localparam int F_RADDR = 11;
	localparam int F_EXP   = 12;
	localparam int F_CHECK = 13;

	// DUT ports
	logic                     clk;
	logic                     rst_n;
	logic                     flush;
	ex_mem_t                  ex_in;
	logic [REG_ADDR_BITS-1:0] rd_addr;
	logic [WORD_WIDTH-1:0]    rd_data;

	// Flat vector storage with FIELDS words per line
	logic [31:0] vec_mem [MAX_VECS*FIELDS];
	int          num_vecs;

	// Bookkeeping
	int cur_test;
	int test_checks;
	int test_errors;
	int checks_total;
	int errors_total;
	int tests_passed;
	int tests_failed;

	rv_backend_top DUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (flush),
		.ex_in   (ex_in),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// Drive one line onto the DUT inputs
	task automatic apply_vector(input int n);
		int base;
		base = n * FIELDS;
		flush             = vec_mem[base+F_FLUSH][0];
		ex_in.pc4         = vec_mem[base+F_PC4];
		ex_in.alu_out     = vec_mem[base+F_ALU];
		ex_in.div_out     = vec_mem[base+F_DIV];
		ex_in.imm         = vec_mem[base+F_IMM];
		ex_in.store_data  = vec_mem[base+F_SDATA];
		ex_in.rd          = vec_mem[base+F_RD][REG_ADDR_BITS-1:0];
		ex_in.wr_en       = vec_mem[base+F_WE][0];
		ex_in.sel_data    = wb_sel_t'(vec_mem[base+F_SEL][2:0]);
		ex_in.mem_op      = mem_op_t'(vec_mem[base+F_MOP][3:0]);
		rd_addr           = vec_mem[base+F_RADDR][REG_ADDR_BITS-1:0];
	endtask

	// Compare the read port with one expected value
	task automatic compare_read(input logic [31:0] exp_data);
		test_checks++;
		checks_total++;
		assert (rd_data === exp_data) else begin
			$display("error %0t: x%0d expected %h, read %h",
				$time, rd_addr, exp_data, rd_data);
			test_errors++;
			errors_total++;
		end
	endtask

	// Check the read port when the line asks for it
	task automatic check_read(input int n);
		int base;
		base = n * FIELDS;
		if (vec_mem[base+F_CHECK][0]) begin
			compare_read(vec_mem[base+F_EXP]);
		end
	endtask

	// Registers aimed at only while in reset must still read zero
	task automatic sweep_reset_targets();
		logic [31:0] in_reset;
		logic [31:0] after_reset;
		int          n;
		int          r;
		in_reset    = '0;
		after_reset = '0;
		for (n = 0; n < num_vecs; n++) begin
			r = vec_mem[n*FIELDS+F_RD][REG_ADDR_BITS-1:0];
			// Line n is captured at the edge closing its cycle
			if (vec_mem[n*FIELDS+F_WE][0]) begin
				if (n + 1 < RESET_CYCLES) begin
					in_reset[r] = 1'b1;
				end else begin
					after_reset[r] = 1'b1;
				end
			end
		end
		for (r = 1; r < 32; r++) begin
			if (in_reset[r] && !after_reset[r]) begin
				@(negedge clk);
				flush   = 1'b0;
				ex_in   = '0;
				rd_addr = r[REG_ADDR_BITS-1:0];
				#(CLK_PERIOD/2 - 1);
				compare_read('0);
			end
		end
	endtask

	// One result line per finished test
	task automatic report_test(input string label);
		if (test_errors == 0) begin
			$display("%s passed, %0d checks", label, test_checks);
			tests_passed++;
		end else begin
			$display("%s failed, %0d of %0d checks wrong",
				label, test_errors, test_checks);
			tests_failed++;
		end
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		int count;
		int n;
		clk          = 1'b0;
		rst_n        = 1'b0;
		flush        = 1'b0;
		ex_in        = '0;
		rd_addr      = '0;
		test_checks  = 0;
		test_errors  = 0;
		checks_total = 0;
		errors_total = 0;
		tests_passed = 0;
		tests_failed = 0;
		$readmemh(VEC_FILE, vec_mem);
		// Lines end where the test column is no longer loaded
		count = 0;
		while (count < MAX_VECS && !$isunknown(vec_mem[count*FIELDS+F_TEST])) begin
			count++;
		end
		num_vecs = count;
		if (num_vecs == 0) begin
			$display("no vectors could be read from %s", VEC_FILE);
			$display("sim failed");
			$finish;
		end else begin
			cur_test = vec_mem[F_TEST];
			for (n = 0; n < num_vecs; n++) begin
				@(negedge clk);
				// Release after RESET_CYCLES rising edges in reset
				if (n + 1 >= RESET_CYCLES) begin
					rst_n = 1'b1;
				end
				if (vec_mem[n*FIELDS+F_TEST] != cur_test) begin
					report_test($sformatf("test %0d", cur_test));
					cur_test = vec_mem[n*FIELDS+F_TEST];
				end
				apply_vector(n);
				// Sample just before the next rising edge
				#(CLK_PERIOD/2 - 1);
				check_read(n);
			end
			report_test($sformatf("test %0d", cur_test));
			sweep_reset_targets();
			report_test("reset targets");
			$display("tests passed %0d, failed %0d, checks %0d, errors %0d",
				tests_passed, tests_failed, checks_total, errors_total);
			if (tests_failed == 0 && errors_total == 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	end

	// Watchdog sized from the vector count
	initial begin
		wait (num_vecs > 0);
		#((num_vecs + RESET_CYCLES + 10) * CLK_PERIOD);
		$display("timeout, the vectors did not finish");
		$display("sim failed");
		$finish;
	end

endmodule

// File: tests/rv_backend_vectors.txt
// test flush pc4 alu_out div_out imm store_data rd wr_en sel_data mem_op rd_addr exp check
// sel 0 alu 1 div 2 load 3 imm 4 pc4, op 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 sb 7 sh 8 sw
// test 1 writes during reset are dropped
1 0 00000004 11111111 00000000 00000000 00000000 05 1 0 0 05 00000000 1
1 0 00000008 22222222 00000000 00000000 00000000 06 1 0 0 06 00000000 1
1 0 0000000c 33333333 00000000 00000000 00000000 07 1 0 0 05 00000000 1
1 0 00000010 44444444 00000000 00000000 00000000 05 1 0 0 07 00000000 1
1 0 00000014 55555555 00000000 00000000 00000000 08 1 0 0 06 00000000 1
1 0 00000018 66666666 00000000 00000000 00000000 09 1 0 0 08 00000000 1
1 0 0000001c 77777777 00000000 00000000 00000000 0a 1 0 0 09 00000000 1
1 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 0a 00000000 1
1 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 05 00000000 1
1 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 08 00000000 1
// test 2 write-back sources
2 0 00000104 0000a5a5 99999999 88888888 00000000 01 1 0 0 01 00000000 1
2 0 00000108 77777777 00000007 66666666 00000000 02 1 1 0 01 00000000 1
2 0 0000010c 55555555 44444444 12345000 00000000 03 1 3 0 01 0000a5a5 1
2 0 00000110 33333333 22222222 11111111 00000000 04 1 4 0 02 00000007 1
2 0 00000114 deadbeef 00000000 00000000 00000000 01 0 0 0 03 12345000 1
2 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 04 00000110 1
2 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 01 0000a5a5 1
// test 3 x0
3 0 00000118 ffffffff 00000000 00000000 00000000 00 1 0 0 00 00000000 1
3 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 00 00000000 1
3 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 00 00000000 1
// test 4 stores and loads on the word at 0x100
4 0 00000000 00000100 00000000 00000000 8899aabb 00 0 0 8 00 00000000 0
4 0 00000000 00000100 00000000 00000000 00000000 0b 1 2 5 00 00000000 0
4 0 00000000 00000101 00000000 00000000 123456f3 00 0 0 6 00 00000000 0
4 0 00000000 00000101 00000000 00000000 00000000 0c 1 2 1 0b 8899aabb 1
4 0 00000000 00000103 00000000 00000000 00000000 0d 1 2 2 0b 8899aabb 1
4 0 00000000 00000102 00000000 00000000 abcd8001 00 0 0 7 0c fffffff3 1
4 0 00000000 00000102 00000000 00000000 00000000 0e 1 2 3 0d 00000088 1
4 0 00000000 00000100 00000000 00000000 00000000 0f 1 2 4 0d 00000088 1
4 0 00000000 00000100 00000000 00000000 0000007f 00 0 0 6 0e ffff8001 1
4 0 00000000 00000100 00000000 00000000 00000000 10 1 2 1 0f 0000f3bb 1
4 0 00000000 00000102 00000000 00000000 00000055 00 0 0 6 0f 0000f3bb 1
4 0 00000000 00000100 00000000 00000000 00000000 11 1 2 5 10 0000007f 1
4 0 00000000 00000100 00000000 00000000 00001234 00 0 0 7 10 0000007f 1
4 0 00000000 00000100 00000000 00000000 00000000 12 1 2 4 11 8055f37f 1
4 0 00000000 00000103 00000000 00000000 000000c6 00 0 0 6 11 8055f37f 1
4 0 00000000 00000103 00000000 00000000 00000000 13 1 2 1 12 00001234 1
4 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 12 00001234 1
4 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 13 ffffffc6 1
// test 5 flush drops the write but keeps the store
5 0 00000200 0000abcd 00000000 00000000 00000000 14 1 0 0 00 00000000 0
5 1 00000204 00000104 00000000 0badf00d cafef00d 15 1 3 8 00 00000000 0
5 0 00000208 00000104 00000000 00000000 00000000 16 1 2 5 14 0000abcd 1
5 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 15 00000000 1
5 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 16 cafef00d 1
// test 6 back-to-back writes to x23
6 0 00000000 11110000 00000000 00000000 00000000 17 1 0 0 00 00000000 0
6 0 00000000 99990000 22220000 00000000 00000000 17 1 1 0 00 00000000 0
6 0 00000000 88880000 00000000 33330000 00000000 17 1 3 0 17 11110000 1
6 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 17 22220000 1
6 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 17 33330000 1
6 0 00000000 00000000 00000000 00000000 00000000 00 0 0 0 17 33330000 1

// File: project.f
logic/rv_backend_pkg.sv
logic/data_mem.sv
logic/mem_stage.sv
logic/pipereg_mem_wb.sv
logic/wb_regfile.sv
logic/rv_backend_top.sv
tests/rv_backend_tb.sv
